/* src.f */
lcd_pkg.sv
lcd_delay_timer.sv
lcd_bus_cycle.sv
lcd_sequencer.sv
lcd16x2.sv
tb_lcd16x2.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_lcd16x2 -o sim_lcd16x2

out="$(./obj_dir/sim_lcd16x2)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
  exit 0
fi
exit 1

/* tb_lcd16x2.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lcd16x2;

  localparam int unsigned CLK_HZ = 1_000_000;  // 1 us per cycle
  localparam int INIT_LEN = 8;
  localparam int INIT_TIMEOUT = 250_000;
  localparam int XFER_TIMEOUT = 2_000;

  localparam logic [7:0] EXP_CMD [0:INIT_LEN-1] = '{
    lcd_pkg::CMD_WAKE, lcd_pkg::CMD_WAKE, lcd_pkg::CMD_WAKE, lcd_pkg::CMD_SETUP,
    lcd_pkg::CMD_DISP_OFF, lcd_pkg::CMD_CLEAR, lcd_pkg::CMD_ENTRY_N, lcd_pkg::CMD_DISP_ON
  };

  // Settle after each init byte in ns
  localparam longint unsigned EXP_SETTLE_NS [0:INIT_LEN-1] = '{
    5_000_000, 100_000, 100_000, 100_000, 60_000, 5_000_000, 60_000, 60_000
  };

  // Time to cycles rounded up and never zero
  function automatic int min_cycles(input longint unsigned t_ns);
    longint unsigned c;
    c = (t_ns * CLK_HZ + 64'd999_999_999) / 64'd1_000_000_000;
    if (c == 0) begin
      c = 1;
    end
    return int'(c);
  endfunction

  localparam int E_HIGH_MIN = min_cycles(40) + min_cycles(250);
  localparam int WRITE_GAP_MIN = min_cycles(250) + min_cycles(42_000);
  localparam int PWR_MIN = min_cycles(100_000_000) + min_cycles(60_000);

  logic       clk_i;
  logic       flag_rst;
  logic       enb_i;
  logic       reinit_i;
  logic [1:0] ops_i;
  logic [7:0] data_i;
  wire        rdy_o;
  wire        lcd_rs_o;
  wire        lcd_e_o;
  wire  [7:0] lcd_data_o;

  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  logic [15:0] lfsr;

  lcd16x2 #(
    .CLK_FREQ_HZ (CLK_HZ)
  ) DUT (
    .clk_i      (clk_i),
    .flag_rst   (flag_rst),
    .enb_i      (enb_i),
    .reinit_i   (reinit_i),
    .ops_i      (ops_i),
    .data_i     (data_i),
    .rdy_o      (rdy_o),
    .lcd_rs_o   (lcd_rs_o),
    .lcd_e_o    (lcd_e_o),
    .lcd_data_o (lcd_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("CHECK FAILED %s: expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    n_checks++;
    assert (act == exp) else begin
      n_errors++;
      $display("CHECK FAILED %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_min(input string name, input int lim, input int act);
    n_checks++;
    assert (act >= lim) else begin
      n_errors++;
      $display("CHECK FAILED %s: expected >= %0d actual %0d", name, lim, act);
    end
  endtask

  ////////////////////
  // Bus monitor
  ////////////////////
  logic       e_prev;
  int         high_cnt;
  int         gap_cnt;
  int         need_gap;
  bit         have_fall;
  bit         first_pending;  // Next rise is the first after a restart
  int         since_kick;
  int         kick_seq;
  int         kick_seen;
  int         rise_count;
  int         init_idx;
  logic       log_rs [$];
  logic [7:0] log_data [$];

  // Samples the bus as it was during the cycle before the edge
  always @(posedge clk_i) begin
    if (flag_rst) begin
      e_prev        = 1'b0;
      high_cnt      = 0;
      gap_cnt       = 0;
      need_gap      = 0;
      have_fall     = 1'b0;
      first_pending = 1'b1;
      since_kick    = 0;
      kick_seen     = kick_seq;
      rise_count    = 0;
      init_idx      = 0;
    end else begin
      if (kick_seq != kick_seen) begin
        kick_seen     = kick_seq;
        since_kick    = 0;
        first_pending = 1'b1;
      end else begin
        since_kick++;
      end
      if (lcd_e_o && !e_prev) begin
        rise_count++;
        if (first_pending) begin
          check_min("power_up_wait", PWR_MIN, since_kick);
          first_pending = 1'b0;
        end else if (have_fall) begin
          check_min("settle_gap", need_gap, gap_cnt);
        end
        high_cnt = 1;
      end else if (lcd_e_o) begin
        high_cnt++;
      end else if (e_prev) begin
        check_min("e_high_width", E_HIGH_MIN, high_cnt);
        log_rs.push_back(lcd_rs_o);
        log_data.push_back(lcd_data_o);
        if (lcd_rs_o) begin
          need_gap = WRITE_GAP_MIN;  // Guard plus 42 us
        end else begin
          need_gap = min_cycles(EXP_SETTLE_NS[init_idx % INIT_LEN]);
          init_idx++;
        end
        have_fall = 1'b1;
        gap_cnt   = 1;
      end else begin
        gap_cnt++;
      end
      e_prev = lcd_e_o;
    end
  end

  a_quiet_before_first_e : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    (rise_count == 0) |-> (!rdy_o && !lcd_rs_o)
  ) else begin
    n_errors++;
    $display("CHECK FAILED quiet_before_first_e: expected rdy/rs 0/0 actual %b/%b",
             rdy_o, lcd_rs_o);
  end

  a_write_drops_rdy : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    (rdy_o && enb_i && ops_i == lcd_pkg::OP_WRITE) |=> !rdy_o
  ) else begin
    n_errors++;
    $display("CHECK FAILED write_drops_rdy: expected 0 actual %b", rdy_o);
  end

  a_busy_while_e : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    lcd_e_o |-> !rdy_o
  ) else begin
    n_errors++;
    $display("CHECK FAILED busy_while_e: expected rdy_o 0 actual %b", rdy_o);
  end

  a_bus_held_at_fall : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    $fell(lcd_e_o) |-> ($stable(lcd_data_o) && $stable(lcd_rs_o))
  ) else begin
    n_errors++;
    $display("CHECK FAILED bus_held_at_fall: expected stable data actual %02h", lcd_data_o);
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;  // Galois taps 16 14 13 11
    end
    return n;
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    int i;
    b = 8'h00;
    for (i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Gives up at once after an earlier timeout
  task automatic wait_rdy(input string what, input int max_cycles);
    int n;
    n = 0;
    while (!rdy_o && n < max_cycles && n_timeouts == 0) begin
      @(negedge clk_i);
      n++;
    end
    if (!rdy_o && n_timeouts == 0) begin
      n_timeouts++;
      $display("Timeout while waiting for %s", what);
    end
  endtask

  // One-cycle strobe that returns on the following falling edge
  task automatic strobe(input logic [1:0] op, input logic [7:0] d);
    @(negedge clk_i);
    enb_i  = 1'b1;
    ops_i  = op;
    data_i = d;
    @(negedge clk_i);
    enb_i  = 1'b0;
    ops_i  = lcd_pkg::OP_NOP;
    data_i = 8'h00;
  endtask

  task automatic run_init_check(input string name);
    int base;
    int i;
    base = log_data.size();
    strobe(lcd_pkg::OP_WRITE, 8'h5A);  // Sent while busy and dropped
    wait_rdy({name, " ready"}, INIT_TIMEOUT);
    if (n_timeouts != 0) return;
    check_int({name, "_e_falls"}, INIT_LEN, log_data.size() - base);
    for (i = 0; i < INIT_LEN && base + i < log_data.size(); i++) begin
      check_bit({name, "_rs"}, 1'b0, log_rs[base + i]);
      check_byte({name, "_cmd"}, EXP_CMD[i], log_data[base + i]);
    end
  endtask

  task automatic write_char(input string name, input logic [7:0] b, input bit busy_strobe);
    int base;
    wait_rdy({name, " idle"}, XFER_TIMEOUT);
    if (n_timeouts != 0) return;
    base = log_data.size();
    strobe(lcd_pkg::OP_WRITE, b);
    check_bit({name, "_rdy_fall"}, 1'b0, rdy_o);
    if (busy_strobe) begin
      strobe(lcd_pkg::OP_WRITE, ~b);
    end
    wait_rdy({name, " done"}, XFER_TIMEOUT);
    if (n_timeouts != 0) return;
    check_int({name, "_e_falls"}, 1, log_data.size() - base);
    if (log_data.size() > base) begin
      check_bit({name, "_rs"}, 1'b1, log_rs[base]);
      check_byte({name, "_data"}, b, log_data[base]);
    end
    check_min({name, "_busy_until_settled"}, WRITE_GAP_MIN, gap_cnt);
  endtask

  task automatic check_ignored_ops();
    int rises;
    int i;
    wait_rdy("idle before NOP", XFER_TIMEOUT);
    if (n_timeouts != 0) return;
    rises = rise_count;
    strobe(lcd_pkg::OP_NOP, 8'h41);
    strobe(2'd3, 8'h42);  // Unused code
    for (i = 0; i < 20; i++) begin
      @(negedge clk_i);
    end
    check_int("nop_e_pulses", rises, rise_count);
    check_bit("nop_rdy", 1'b1, rdy_o);
  endtask

  task automatic start_reinit(input bit use_level);
    wait_rdy("idle before re-init", XFER_TIMEOUT);
    if (n_timeouts != 0) return;
    @(negedge clk_i);
    kick_seq++;
    if (use_level) begin
      reinit_i = 1'b1;
    end else begin
      enb_i = 1'b1;
      ops_i = lcd_pkg::OP_RESET;
    end
    @(negedge clk_i);
    reinit_i = 1'b0;
    enb_i    = 1'b0;
    ops_i    = lcd_pkg::OP_NOP;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    logic [7:0] ch;
    int k;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    kick_seq   = 0;
    lfsr       = 16'd59651;
    flag_rst   = 1'b1;
    enb_i      = 1'b0;
    reinit_i   = 1'b0;
    ops_i      = lcd_pkg::OP_NOP;
    data_i     = 8'h00;
    repeat (16) @(negedge clk_i);
    check_bit("reset_rdy", 1'b0, rdy_o);
    check_bit("reset_e", 1'b0, lcd_e_o);
    check_bit("reset_rs", 1'b0, lcd_rs_o);
    check_byte("reset_data", 8'h00, lcd_data_o);
    flag_rst = 1'b0;

    run_init_check("power_on_init");
    for (k = 0; k < 6; k++) begin
      rand_byte(ch);
      write_char("write", ch, k == 2);
    end
    check_ignored_ops();

    start_reinit(1'b0);
    run_init_check("op_reset_init");
    rand_byte(ch);
    write_char("write_after_op_reset", ch, 1'b0);

    start_reinit(1'b1);
    run_init_check("reinit_level_init");
    rand_byte(ch);
    write_char("write_after_reinit", ch, 1'b1);

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* lcd16x2.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd16x2 #(
  parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
  input  wire        clk_i,
  input  wire        flag_rst,
  input  wire        enb_i,
  input  wire        reinit_i,
  input  wire  [1:0] ops_i,
  input  wire  [7:0] data_i,
  output logic       rdy_o,
  output logic       lcd_rs_o,
  output logic       lcd_e_o,
  output logic [7:0] lcd_data_o
);

  // Sequencer to bus-cycle engine
  logic                 xfer_start;
  logic                 xfer_rs;
  logic [7:0]           xfer_data;
  lcd_pkg::lcd_settle_e xfer_settle;
  logic                 xfer_done;

  // Power-up and E low waits
  logic                      pwr_start;
  logic [lcd_pkg::CNT_W-1:0] pwr_cycles;
  logic                      pwr_done;

  lcd_sequencer #(
    .CLK_FREQ_HZ (CLK_FREQ_HZ)
  ) u_sequencer (
    .clk_i         (clk_i),
    .flag_rst      (flag_rst),
    .enb_i         (enb_i),
    .reinit_i      (reinit_i),
    .ops_i         (lcd_pkg::lcd_op_e'(ops_i)),
    .data_i        (data_i),
    .xfer_done_i   (xfer_done),
    .pwr_done_i    (pwr_done),
    .xfer_start_o  (xfer_start),
    .xfer_rs_o     (xfer_rs),
    .xfer_data_o   (xfer_data),
    .xfer_settle_o (xfer_settle),
    .pwr_start_o   (pwr_start),
    .pwr_cycles_o  (pwr_cycles),
    .rdy_o         (rdy_o)
  );

  lcd_bus_cycle #(
    .CLK_FREQ_HZ (CLK_FREQ_HZ)
  ) u_bus_cycle (
    .clk_i         (clk_i),
    .flag_rst      (flag_rst),
    .xfer_start_i  (xfer_start),
    .xfer_rs_i     (xfer_rs),
    .xfer_data_i   (xfer_data),
    .xfer_settle_i (xfer_settle),
    .xfer_done_o   (xfer_done),
    .lcd_e_o       (lcd_e_o),
    .lcd_rs_o      (lcd_rs_o),
    .lcd_data_o    (lcd_data_o)
  );

  lcd_delay_timer u_pwr_timer (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (pwr_start),
    .cycles_i (pwr_cycles),
    .done_o   (pwr_done)
  );

endmodule

`default_nettype wire

/* lcd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer #(
  parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
  input  wire                       clk_i,
  input  wire                       flag_rst,
  input  wire                       enb_i,
  input  wire                       reinit_i,
  input  wire  lcd_pkg::lcd_op_e    ops_i,
  input  wire  [7:0]                data_i,
  input  wire                       xfer_done_i,
  input  wire                       pwr_done_i,
  output logic                      xfer_start_o,
  output logic                      xfer_rs_o,
  output logic [7:0]                xfer_data_o,
  output lcd_pkg::lcd_settle_e      xfer_settle_o,
  output logic                      pwr_start_o,
  output logic [lcd_pkg::CNT_W-1:0] pwr_cycles_o,
  output logic                      rdy_o
);

  localparam int W = lcd_pkg::CNT_W;

  localparam logic [W-1:0] T_100_MS = lcd_pkg::ns_to_cycles(100_000_000, CLK_FREQ_HZ);
  localparam logic [W-1:0] T_60_US  = lcd_pkg::ns_to_cycles(60_000, CLK_FREQ_HZ);

  localparam logic [2:0] LAST_STEP = 3'(lcd_pkg::INIT_STEPS - 1);

  typedef enum logic [2:0] {
    ST_BOOT,       // Kick the power-up timer
    ST_PWR_WAIT,
    ST_ELOW_WAIT,
    ST_INIT,       // Walks the init table
    ST_IDLE,
    ST_WRITE
  } state_e;

  state_e     state;
  logic [2:0] step;
  logic [7:0] wr_data_q;
  logic       xfer_pending;

  ////////////////////
  // Init and idle FSM
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      state        <= ST_BOOT;
      step         <= '0;
      xfer_start_o <= 1'b0;
      pwr_start_o  <= 1'b0;
    end else begin
      xfer_start_o <= 1'b0;
      pwr_start_o  <= 1'b0;
      case (state)
        ST_BOOT: begin
          pwr_start_o <= 1'b1;
          state       <= ST_PWR_WAIT;
        end
        ST_PWR_WAIT: begin
          if (pwr_done_i) begin
            pwr_start_o <= 1'b1;  // Same timer again for the E low wait
            state       <= ST_ELOW_WAIT;
          end
        end
        ST_ELOW_WAIT: begin
          if (pwr_done_i) begin
            step         <= '0;
            xfer_start_o <= 1'b1;
            state        <= ST_INIT;
          end
        end
        ST_INIT: begin
          if (xfer_done_i) begin
            if (step == LAST_STEP) begin
              state <= ST_IDLE;
            end else begin
              step         <= step + 1'b1;
              xfer_start_o <= 1'b1;
            end
          end
        end
        ST_IDLE: begin
          if (reinit_i) begin
            state <= ST_BOOT;
          end else if (enb_i) begin
            case (ops_i)
              lcd_pkg::OP_WRITE: begin
                xfer_start_o <= 1'b1;
                state        <= ST_WRITE;
              end
              lcd_pkg::OP_RESET: state <= ST_BOOT;
              default: state <= ST_IDLE;  // NOP and unused code
            endcase
          end
        end
        ST_WRITE: begin
          if (xfer_done_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_BOOT;
      endcase
    end
  end

  // Character captured on the strobe
  always_ff @(posedge clk_i) begin
    if (rdy_o && enb_i && (ops_i == lcd_pkg::OP_WRITE)) begin
      wr_data_q <= data_i;
    end
  end

  assign rdy_o     = (state == ST_IDLE);
  assign xfer_rs_o = (state == ST_WRITE);  // RS high only for characters

  // Transfer fields valid while xfer_start_o is high
  assign xfer_data_o   = (state == ST_WRITE) ? wr_data_q : lcd_pkg::INIT_CMD[step];
  assign xfer_settle_o = (state == ST_WRITE) ? lcd_pkg::SETTLE_42_US
                                             : lcd_pkg::INIT_SETTLE[step];

  assign pwr_cycles_o = (state == ST_ELOW_WAIT) ? T_60_US : T_100_MS;

  // Open transfer between start and done
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      xfer_pending <= 1'b0;
    end else if (xfer_start_o) begin
      xfer_pending <= 1'b1;
    end else if (xfer_done_i) begin
      xfer_pending <= 1'b0;
    end
  end

  a_one_xfer : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    xfer_start_o |-> !xfer_pending
  ) else $error("transfer started while one is outstanding");

endmodule

`default_nettype wire

/* lcd_bus_cycle.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_cycle #(
  parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
  input  wire                        clk_i,
  input  wire                        flag_rst,
  input  wire                        xfer_start_i,
  input  wire                        xfer_rs_i,
  input  wire  [7:0]                 xfer_data_i,
  input  wire  lcd_pkg::lcd_settle_e xfer_settle_i,
  output logic                       xfer_done_o,
  output logic                       lcd_e_o,
  output logic                       lcd_rs_o,
  output logic [7:0]                 lcd_data_o
);

  localparam int W = lcd_pkg::CNT_W;

  localparam logic [W-1:0] T_40_NS   = lcd_pkg::ns_to_cycles(40, CLK_FREQ_HZ);
  localparam logic [W-1:0] T_250_NS  = lcd_pkg::ns_to_cycles(250, CLK_FREQ_HZ);
  localparam logic [W-1:0] T_42_US   = lcd_pkg::ns_to_cycles(42_000, CLK_FREQ_HZ);
  localparam logic [W-1:0] T_60_US   = lcd_pkg::ns_to_cycles(60_000, CLK_FREQ_HZ);
  localparam logic [W-1:0] T_100_US  = lcd_pkg::ns_to_cycles(100_000, CLK_FREQ_HZ);
  localparam logic [W-1:0] T_5000_US = lcd_pkg::ns_to_cycles(5_000_000, CLK_FREQ_HZ);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SETUP,   // E high before data
    PH_HOLD,    // Data valid with E high
    PH_GUARD,   // Extra wait after a write
    PH_SETTLE
  } phase_e;

  phase_e               phase;
  lcd_pkg::lcd_settle_e settle_q;
  logic [7:0]           data_q;
  logic                 tmr_start;
  logic [W-1:0]         tmr_cycles;
  logic                 tmr_done;

  // Count for the phase that the timer is starting
  always_comb begin
    case (phase)
      PH_SETUP: tmr_cycles = T_40_NS;
      PH_HOLD:  tmr_cycles = T_250_NS;
      PH_GUARD: tmr_cycles = T_250_NS;
      PH_SETTLE: begin
        case (settle_q)
          lcd_pkg::SETTLE_42_US:  tmr_cycles = T_42_US;
          lcd_pkg::SETTLE_60_US:  tmr_cycles = T_60_US;
          lcd_pkg::SETTLE_100_US: tmr_cycles = T_100_US;
          default:                tmr_cycles = T_5000_US;
        endcase
      end
      default: tmr_cycles = T_40_NS;
    endcase
  end

  ////////////////////
  // Phase FSM
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      phase       <= PH_IDLE;
      settle_q    <= lcd_pkg::SETTLE_42_US;
      tmr_start   <= 1'b0;
      xfer_done_o <= 1'b0;
      lcd_e_o     <= 1'b0;
      lcd_rs_o    <= 1'b0;
      lcd_data_o  <= 8'h00;
    end else begin
      tmr_start   <= 1'b0;
      xfer_done_o <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (xfer_start_i) begin
            lcd_e_o   <= 1'b1;
            lcd_rs_o  <= xfer_rs_i;
            settle_q  <= xfer_settle_i;
            tmr_start <= 1'b1;
            phase     <= PH_SETUP;
          end
        end
        PH_SETUP: begin
          if (tmr_done) begin
            lcd_data_o <= data_q;  // Byte goes out after setup
            tmr_start  <= 1'b1;
            phase      <= PH_HOLD;
          end
        end
        PH_HOLD: begin
          if (tmr_done) begin
            lcd_e_o   <= 1'b0;  // LCD latches on this edge
            tmr_start <= 1'b1;
            if (settle_q == lcd_pkg::SETTLE_42_US) begin
              phase <= PH_GUARD;
            end else begin
              phase <= PH_SETTLE;
            end
          end
        end
        PH_GUARD: begin
          if (tmr_done) begin
            tmr_start <= 1'b1;
            phase     <= PH_SETTLE;
          end
        end
        PH_SETTLE: begin
          if (tmr_done) begin
            xfer_done_o <= 1'b1;
            phase       <= PH_IDLE;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // Byte held until the end of the setup count
  always_ff @(posedge clk_i) begin
    if (xfer_start_i && (phase == PH_IDLE)) begin
      data_q <= xfer_data_i;
    end
  end

  lcd_delay_timer u_timer (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .start_i  (tmr_start),
    .cycles_i (tmr_cycles),
    .done_o   (tmr_done)
  );

  a_rs_stable : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    lcd_e_o && $past(lcd_e_o) |-> $stable(lcd_rs_o)
  ) else $error("RS changed while E high");

  a_done_after_fall : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    xfer_done_o |-> !lcd_e_o && !$past(lcd_e_o)
  ) else $error("transfer done before E fell");

endmodule

`default_nettype wire

/* lcd_delay_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_delay_timer (
  input  wire                      clk_i,
  input  wire                      flag_rst,
  input  wire                      start_i,
  input  wire [lcd_pkg::CNT_W-1:0] cycles_i,
  output logic                     done_o
);

  logic [lcd_pkg::CNT_W-1:0] cnt;
  logic                      run;

  ////////////////////
  // Down-counter
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      cnt <= '0;
      run <= 1'b0;
    end else if (start_i) begin
      // A zero count acts as one
      cnt <= (cycles_i == '0) ? '0 : cycles_i - 1'b1;
      run <= 1'b1;
    end else if (run) begin
      if (cnt == '0) begin
        run <= 1'b0;  // Done cycle
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // High N cycles after the start that loaded N
  assign done_o = run && (cnt == '0);

  a_no_restart : assert property (
    @(posedge clk_i) disable iff (flag_rst)
    start_i |-> !run
  ) else $error("delay timer started while running");

endmodule

`default_nettype wire

/* lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

  ////////////////////
  // Types
  ////////////////////

  // Opcodes sampled on ops_i
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_WRITE = 2'd1,  // Put one character
    OP_RESET = 2'd2   // Rerun the whole init
  } lcd_op_e;

  // Wait after the falling edge of E
  typedef enum logic [2:0] {
    SETTLE_42_US   = 3'd0,  // Character write class
    SETTLE_60_US   = 3'd1,
    SETTLE_100_US  = 3'd2,
    SETTLE_5000_US = 3'd3
  } lcd_settle_e;

  ////////////////////
  // Command bytes
  ////////////////////
  parameter logic [7:0] CMD_WAKE     = 8'h30;  // Function set for 8-bit bus
  parameter logic [7:0] CMD_SETUP    = 8'h38;  // 8-bit 2 lines 5x7 dots
  parameter logic [7:0] CMD_DISP_OFF = 8'h08;
  parameter logic [7:0] CMD_CLEAR    = 8'h01;
  parameter logic [7:0] CMD_ENTRY_N  = 8'h06;  // Cursor moves and display stands still
  parameter logic [7:0] CMD_DISP_ON  = 8'h0C;

  // Init transfers in bus order
  parameter int INIT_STEPS = 8;

  parameter logic [7:0] INIT_CMD [0:INIT_STEPS-1] = '{
    CMD_WAKE, CMD_WAKE, CMD_WAKE, CMD_SETUP,
    CMD_DISP_OFF, CMD_CLEAR, CMD_ENTRY_N, CMD_DISP_ON
  };

  parameter lcd_settle_e INIT_SETTLE [0:INIT_STEPS-1] = '{
    SETTLE_5000_US, SETTLE_100_US, SETTLE_100_US, SETTLE_100_US,
    SETTLE_60_US, SETTLE_5000_US, SETTLE_60_US, SETTLE_60_US
  };

  parameter int CNT_W = 24;  // 100 ms up to about 160 MHz

  // Nanoseconds to clock cycles rounded up
  function automatic logic [CNT_W-1:0] ns_to_cycles(input longint unsigned t_ns,
                                                   input longint unsigned clk_hz);
    longint unsigned cyc;
    cyc = (t_ns * clk_hz + 64'd999_999_999) / 64'd1_000_000_000;
    if (cyc == 64'd0) begin
      cyc = 64'd1;  // Never a zero wait
    end
    return cyc[CNT_W-1:0];
  endfunction

endpackage

`default_nettype wire
